// ==== hdl/snac_pkg.sv ====
package snac_pkg;

    // pad types on the SNAC port, configuration A only
    // any value not listed here behaves as disabled
    typedef enum logic [4:0] {
        GC_DISABLED  = 5'd0,
        GC_DB15      = 5'd1,
        GC_NES       = 5'd2,
        GC_SNES      = 5'd3,
        GC_DB15_FAST = 5'd9
    } pad_type_t;

    // one player, bit k is button k, 1 = pressed
    typedef logic [15:0] btn_word_t;

    // phase increment of the strobe accumulator
    typedef logic [31:0] step_t;

    // polling rates in Hz
    localparam int unsigned DB15_POLL_HZ      = 200_000;
    localparam int unsigned DB15_FAST_POLL_HZ = 400_000;
    // NES and SNES share the slow rate
    localparam int unsigned SERLATCH_POLL_HZ  = 50_000;

    // bits per frame
    localparam int NES_BITS  = 8;
    localparam int WIDE_BITS = 12;

    // APB register map
    localparam int              APB_ADDR_W = 4;
    localparam [APB_ADDR_W-1:0] CFG_ADDR   = '0;

    // sequencer runs at twice the polling rate
    // step = 2^32 * 2 * poll / clk, truncated
    function automatic step_t calc_step(input int unsigned poll_hz,
                                        input int unsigned clk_hz);
        logic [63:0] num;
        logic [63:0] quo;
        num = 64'(poll_hz) * 64'd2;
        num = num << 32;
        quo = num / 64'(clk_hz);
        return quo[31:0];
    endfunction

endpackage

// ==== hdl/snac_cfg_if.sv ====
`timescale 1ns/1ps

// decoded pad configuration, register stage to strobe and reader
interface snac_cfg_if import snac_pkg::*; ();

    pad_type_t pad_type;
    step_t     step;
    logic      enable;
    // single cycle, fires when the stored type changes
    logic      restart;

    modport cfg (output pad_type, output step, output enable, output restart);

    // accumulator only needs the rate
    modport strobe (input step, input enable, input restart);

    // frame length depends on the type
    modport reader (input pad_type, input enable, input restart);

endinterface

// ==== hdl/snac_cfg_apb.sv ====
`timescale 1ns/1ps

module snac_cfg_apb import snac_pkg::*; #(
    parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [4:0]            i_pwdata,
    output logic [4:0]            o_prdata,
    snac_cfg_if.cfg               cfg_o
);

    // per-rate phase increments, fixed by the clock frequency
    localparam step_t STEP_DB15      = calc_step(DB15_POLL_HZ, CLK_FREQ_HZ);
    localparam step_t STEP_DB15_FAST = calc_step(DB15_FAST_POLL_HZ, CLK_FREQ_HZ);
    localparam step_t STEP_SERLATCH  = calc_step(SERLATCH_POLL_HZ, CLK_FREQ_HZ);

    logic [4:0] type_q;
    logic       wr_en;
    pad_type_t  dec_type;
    step_t      dec_step;
    logic       dec_en;

    // access phase of a write to the type register, no wait states
    assign wr_en = i_psel && i_penable && i_pwrite && (i_paddr == CFG_ADDR);

    // readback of the raw value, zero elsewhere
    assign o_prdata = (i_psel && !i_pwrite && (i_paddr == CFG_ADDR)) ? type_q : 5'd0;

    // decode the incoming value to type, rate and enable
    always_comb begin
        dec_type = GC_DISABLED;
        dec_step = '0;
        dec_en   = 1'b0;
        case (i_pwdata)
            GC_DB15: begin
                dec_type = GC_DB15;
                dec_step = STEP_DB15;
                dec_en   = 1'b1;
            end
            GC_DB15_FAST: begin
                dec_type = GC_DB15_FAST;
                dec_step = STEP_DB15_FAST;
                dec_en   = 1'b1;
            end
            GC_NES, GC_SNES: begin
                dec_type = pad_type_t'(i_pwdata);
                dec_step = STEP_SERLATCH;
                dec_en   = 1'b1;
            end
            // unsupported codes stay stored but act as disabled
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            type_q         <= GC_DISABLED;
            cfg_o.pad_type <= GC_DISABLED;
            cfg_o.step     <= '0;
            cfg_o.enable   <= 1'b0;
            cfg_o.restart  <= 1'b0;
        end else begin
            // restart only on a real change of the stored value
            cfg_o.restart <= wr_en && (i_pwdata != type_q);
            if (wr_en) begin
                type_q         <= i_pwdata;
                cfg_o.pad_type <= dec_type;
                cfg_o.step     <= dec_step;
                cfg_o.enable   <= dec_en;
            end
        end
    end

endmodule

// ==== hdl/snac_strobe_gen.sv ====
`timescale 1ns/1ps

module snac_strobe_gen import snac_pkg::*; (
    input  logic          i_clk,
    input  logic          i_reset,
    snac_cfg_if.strobe    cfg_i,
    output logic          o_stb
);

    step_t       phase_q;
    logic [32:0] sum;

    // carry out of the 32-bit phase is the strobe
    assign sum = {1'b0, phase_q} + {1'b0, cfg_i.step};

    always_ff @(posedge i_clk) begin
        if (i_reset || cfg_i.restart || !cfg_i.enable) begin
            // new rate starts from a clean phase
            phase_q <= '0;
            o_stb   <= 1'b0;
        end else begin
            phase_q <= sum[31:0];
            // fractional step, so the pulse spacing jitters by one clock
            o_stb   <= sum[32];
        end
    end

endmodule

// ==== hdl/serlatch_reader.sv ====
`timescale 1ns/1ps

module serlatch_reader import snac_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_stb,
    input  logic       i_dat1,
    input  logic       i_dat2,
    snac_cfg_if.reader cfg_i,
    output logic       o_pad_clk,
    output logic       o_pad_latch,
    output logic       o_busy,
    output btn_word_t  o_p1_btn,
    output btn_word_t  o_p2_btn
);

    localparam int SR_W = WIDE_BITS;

    // two-flop synchronizers, pad data is asynchronous
    logic [1:0]      dat1_ff;
    logic [1:0]      dat2_ff;
    logic [4:0]      tick_q;
    logic [4:0]      last_tick;
    logic            is_nes;
    logic            stb_run;
    logic            sample;
    logic            frame_done;
    logic [SR_W-1:0] sr1;
    logic [SR_W-1:0] sr2;
    btn_word_t       p1_next;
    btn_word_t       p2_next;

    assign is_nes = (cfg_i.pad_type == GC_NES);

    // frame is 2N+1 strobes, tick 0 .. tick 2N
    assign last_tick = is_nes ? 5'(2 * NES_BITS) : 5'(2 * WIDE_BITS);

    // strobe that may advance the frame this cycle
    assign stb_run = i_stb && cfg_i.enable && !cfg_i.restart;

    // odd ticks sample, bit k on tick 2k+1
    assign sample     = stb_run && o_busy && tick_q[0];
    assign frame_done = stb_run && o_busy && !tick_q[0] && (tick_q == last_tick);

    always_ff @(posedge i_clk) begin
        dat1_ff <= {dat1_ff[0], i_dat1};
        dat2_ff <= {dat2_ff[0], i_dat2};
    end

    // frame sequencer
    always_ff @(posedge i_clk) begin
        if (i_reset || cfg_i.restart || !cfg_i.enable) begin
            o_busy      <= 1'b0;
            o_pad_latch <= 1'b0;
            // pad clock idles high
            o_pad_clk   <= 1'b1;
            tick_q      <= '0;
        end else if (i_stb) begin
            if (!o_busy) begin
                // tick 0, latch the pad state
                o_busy      <= 1'b1;
                o_pad_latch <= 1'b1;
                o_pad_clk   <= 1'b1;
                tick_q      <= 5'd1;
            end else if (tick_q[0]) begin
                // falling clock, data bit is valid now
                o_pad_latch <= 1'b0;
                o_pad_clk   <= 1'b0;
                tick_q      <= tick_q + 5'd1;
            end else begin
                // rising clock shifts the pad to its next bit
                o_pad_clk <= 1'b1;
                tick_q    <= tick_q + 5'd1;
                if (tick_q == last_tick) begin
                    o_busy <= 1'b0;
                    tick_q <= '0;
                end
            end
        end
    end

    // lines are active low, store pressed as 1
    // first bit ends up in the lsb after the last shift
    always_ff @(posedge i_clk) begin
        if (sample) begin
            sr1 <= {~dat1_ff[1], sr1[SR_W-1:1]};
            sr2 <= {~dat2_ff[1], sr2[SR_W-1:1]};
        end
    end

    // nes only fills the top 8 positions of the shifter
    always_comb begin
        if (is_nes) begin
            p1_next = {{(16 - NES_BITS){1'b0}}, sr1[SR_W-1 -: NES_BITS]};
            p2_next = {{(16 - NES_BITS){1'b0}}, sr2[SR_W-1 -: NES_BITS]};
        end else begin
            p1_next = {{(16 - SR_W){1'b0}}, sr1};
            p2_next = {{(16 - SR_W){1'b0}}, sr2};
        end
    end

    // words update in the cycle busy falls
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_p1_btn <= '0;
            o_p2_btn <= '0;
        end else if (frame_done) begin
            o_p1_btn <= p1_next;
            o_p2_btn <= p2_next;
        end
    end

endmodule

// ==== hdl/snac_top.sv ====
`timescale 1ns/1ps

module snac_top import snac_pkg::*; #(
    parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    // APB slave, zero wait states
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [4:0]            i_pwdata,
    output logic [4:0]            o_prdata,
    // button words
    output btn_word_t             o_p1_btn,
    output btn_word_t             o_p2_btn,
    output logic                  o_busy,
    // cartridge port, configuration A
    input  logic [7:4]            i_cart_bk0_in,
    output logic                  o_cart_bk0_dir,
    output logic [1:0]            o_cart_bk1_out,
    output logic                  o_cart_pin30_out,
    output logic                  o_cart_pin30_dir
);

    snac_cfg_if cfg_bus ();

    logic stb;
    logic pad_clk;
    logic pad_latch;

    snac_cfg_apb #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ)
    ) u_cfg_apb (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .cfg_o     (cfg_bus.cfg)
    );

    snac_strobe_gen u_strobe_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .cfg_i   (cfg_bus.strobe),
        .o_stb   (stb)
    );

    // IO3 is player 1 data, IN7 is player 2 data
    serlatch_reader u_reader (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_stb       (stb),
        .i_dat1      (i_cart_bk0_in[4]),
        .i_dat2      (i_cart_bk0_in[5]),
        .cfg_i       (cfg_bus.reader),
        .o_pad_clk   (pad_clk),
        .o_pad_latch (pad_latch),
        .o_busy      (o_busy),
        .o_p1_btn    (o_p1_btn),
        .o_p2_btn    (o_p2_btn)
    );

    // OUT1 clock, OUT2 latch
    assign o_cart_bk1_out   = {pad_latch, pad_clk};
    // second pad gets its own copy of the clock on IO5
    assign o_cart_pin30_out = pad_clk;
    // bank 0 is input only, pin 30 drives
    assign o_cart_bk0_dir   = 1'b0;
    assign o_cart_pin30_dir = 1'b1;

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

// free-running clock, reset held high for the first few rising edges
module tb_clk_gen #(
    parameter int HALF_NS      = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_NS) o_clk = ~o_clk;
    end

    // released on a rising edge like any other stimulus
    initial begin
        o_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

// ==== tb/snac_assert.sv ====
`timescale 1ns/1ps

module snac_assert (
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_busy,
    input logic [1:0] i_pad_out,
    input logic       i_bk0_dir
);

    // failing assertions, read back at the end of the run
    int unsigned hits = 0;

    // latch only ever rises inside a frame
    latch_in_frame: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pad_out[1] |-> i_busy)
    else begin
        hits = hits + 1;
        $error("latch high while no frame is running");
    end

    // bank 0 is an input bank
    bk0_dir_input: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bk0_dir == 1'b0)
    else begin
        hits = hits + 1;
        $error("bank 0 direction left input mode");
    end

    // pad clock idles high outside a frame
    clk_low_in_frame: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_pad_out[0] |-> i_busy)
    else begin
        hits = hits + 1;
        $error("pad clock low while no frame is running");
    end

endmodule

bind snac_top snac_assert u_assert (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_busy    (o_busy),
    .i_pad_out (o_cart_bk1_out),
    .i_bk0_dir (o_cart_bk0_dir)
);

// ==== tb/snac_tb.sv ====
`timescale 1ns/1ps

// behavioral serial-latch pad, data line is active low
module serial_pad (
    input  logic        i_pad_clk,
    input  logic        i_latch,
    input  logic [15:0] i_word,
    output logic        o_data,
    output logic [15:0] o_held
);

    logic [3:0]  idx  = 4'd0;
    logic [15:0] held = 16'h0000;

    // latch reloads and rewinds, each rising pad clock moves to the next bit
    always @(posedge i_pad_clk or posedge i_latch) begin
        if (i_latch) begin
            idx  <= 4'd0;
            held <= i_word;
        end else if (idx != 4'd15) begin
            idx <= idx + 4'd1;
        end
    end

    assign o_data = ~held[idx];
    assign o_held = held;

endmodule

module snac_tb import snac_pkg::*; ();

    localparam int unsigned CLK_HZ = 5_000_000;
    localparam int DB15_FRAMES = 6;
    localparam int NES_FRAMES  = 6;
    localparam int SNES_FRAMES = 3;
    localparam int FAST_FRAMES = 6;
    // extra frames cover the aborted frame and the idle windows
    localparam int TOTAL_FRAMES = DB15_FRAMES + NES_FRAMES + SNES_FRAMES + FAST_FRAMES + 4;
    // slowest strobe, plus one clock of fractional jitter
    localparam int MAX_STB_CLKS  = CLK_HZ / (2 * SERLATCH_POLL_HZ) + 1;
    localparam int WATCHDOG_CLKS = TOTAL_FRAMES * 25 * MAX_STB_CLKS * 4;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [4:0]            pwdata;
    logic [4:0]            prdata;
    btn_word_t             p1_btn;
    btn_word_t             p2_btn;
    logic                  busy;
    logic                  bk0_dir;
    logic [1:0]            bk1_out;
    logic                  pin30_out;
    logic                  pin30_dir;
    logic                  p1_dat;
    logic                  p2_dat;
    logic [15:0]           p1_word = 16'h0000;
    logic [15:0]           p2_word = 16'h0000;
    logic [15:0]           p1_held;
    logic [15:0]           p2_held;

    // compare state, owned by the main sequence
    logic        check_en    = 1'b0;
    pad_type_t   cur_type    = GC_DISABLED;
    string       cur_test    = "";
    int          err_count   = 0;
    int          test_base   = 0;
    int          pass_tests  = 0;
    int          fail_tests  = 0;
    // owned by the compare process
    int          frames_done = 0;
    logic        busy_prev   = 1'b0;
    logic [31:0] seed        = 32'hf6c5;
    // expected words of the last checked frame
    btn_word_t   last_exp1   = 16'h0000;
    btn_word_t   last_exp2   = 16'h0000;

    tb_clk_gen #(.HALF_NS(10), .RESET_CYCLES(3)) u_clk_gen (.o_clk(clk), .o_reset(rst));

    snac_top #(.CLK_FREQ_HZ(CLK_HZ)) i_snac_top (
        .i_clk            (clk),
        .i_reset          (rst),
        .i_psel           (psel),
        .i_penable        (penable),
        .i_pwrite         (pwrite),
        .i_paddr          (paddr),
        .i_pwdata         (pwdata),
        .o_prdata         (prdata),
        .o_p1_btn         (p1_btn),
        .o_p2_btn         (p2_btn),
        .o_busy           (busy),
        .i_cart_bk0_in    ({2'b11, p2_dat, p1_dat}),
        .o_cart_bk0_dir   (bk0_dir),
        .o_cart_bk1_out   (bk1_out),
        .o_cart_pin30_out (pin30_out),
        .o_cart_pin30_dir (pin30_dir)
    );

    // player 2 runs off the pin 30 copy of the clock
    serial_pad u_pad1 (.i_pad_clk(bk1_out[0]), .i_latch(bk1_out[1]), .i_word(p1_word),
                       .o_data(p1_dat), .o_held(p1_held));
    serial_pad u_pad2 (.i_pad_clk(pin30_out), .i_latch(bk1_out[1]), .i_word(p2_word),
                       .o_data(p2_dat), .o_held(p2_held));

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // NES reports 8 buttons, the other pads 12
    function automatic btn_word_t ref_word(input pad_type_t t, input logic [15:0] w);
        if (t == GC_NES)
            return w & 16'h00ff;
        return w & 16'h0fff;
    endfunction

    task automatic check_btn(input string what, input btn_word_t exp, input btn_word_t act);
        if (exp !== act) begin
            $display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
            err_count = err_count + 1;
        end
    endtask

    task automatic check_type(input string what, input pad_type_t exp, input pad_type_t act);
        if (exp !== act) begin
            $display("Fail %s %s expected %0d actual %0d", cur_test, what, exp, act);
            err_count = err_count + 1;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s %s expected %b actual %b", cur_test, what, exp, act);
            err_count = err_count + 1;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_base) begin
            $display("test %s passed", cur_test);
            pass_tests = pass_tests + 1;
        end else begin
            $display("test %s had %0d errors", cur_test, err_count - test_base);
            fail_tests = fail_tests + 1;
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [4:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [4:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // read data is combinational in the access cycle
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // the restart aborts a running frame, so comparing stops first
    task automatic write_type(input pad_type_t t);
        @(posedge clk);
        check_en = 1'b0;
        apb_write(CFG_ADDR, t);
    endtask

    task automatic arm_check(input pad_type_t t);
        repeat (3) @(posedge clk);
        cur_type = t;
        check_en = 1'b1;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) @(posedge clk);
    endtask

    task automatic watch_latch_idle(input int cycles);
        int highs;
        highs = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (bk1_out[1])
                highs = highs + 1;
        end
        if (highs != 0) begin
            $display("%s latch was high for %0d cycles with no pad active", cur_test, highs);
            err_count = err_count + 1;
        end
    endtask

    // end of each frame, check against what the pads latched, then new words
    always @(negedge clk) begin
        if (busy_prev && !busy) begin
            if (check_en) begin
                last_exp1 = ref_word(cur_type, p1_held);
                last_exp2 = ref_word(cur_type, p2_held);
                check_btn("p1 word", last_exp1, p1_btn);
                check_btn("p2 word", last_exp2, p2_btn);
                frames_done = frames_done + 1;
            end
            seed = lcg_next(seed);
            p1_word <= seed[31:16];
            seed = lcg_next(seed);
            p2_word <= seed[31:16];
        end
        busy_prev = busy;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("watchdog expired, frames stopped completing");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [4:0] rd;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        @(negedge clk);
        while (rst) @(negedge clk);

        begin_test("reset");
        check_bit("busy", 1'b0, busy);
        check_bit("latch", 1'b0, bk1_out[1]);
        check_bit("pad clock", 1'b1, bk1_out[0]);
        check_bit("pin 30 clock", 1'b1, pin30_out);
        check_bit("bank 0 dir", 1'b0, bk0_dir);
        check_bit("pin 30 dir", 1'b1, pin30_dir);
        check_btn("p1 word", 16'h0000, p1_btn);
        check_btn("p2 word", 16'h0000, p2_btn);
        apb_read(CFG_ADDR, rd);
        check_type("type readback", GC_DISABLED, pad_type_t'(rd));
        end_test();

        begin_test("apb");
        apb_write(CFG_ADDR, GC_DB15);
        apb_read(CFG_ADDR, rd);
        check_type("db15 readback", GC_DB15, pad_type_t'(rd));
        // unsupported code is stored but disables the reader
        apb_write(CFG_ADDR, 5'd7);
        apb_read(CFG_ADDR, rd);
        check_type("raw readback", pad_type_t'(5'd7), pad_type_t'(rd));
        watch_latch_idle(200);
        apb_read(4'd3, rd);
        check_type("other address", GC_DISABLED, pad_type_t'(rd));
        end_test();

        begin_test("db15");
        write_type(GC_DB15);
        arm_check(GC_DB15);
        wait_frames(DB15_FRAMES);
        end_test();

        begin_test("nes");
        write_type(GC_NES);
        arm_check(GC_NES);
        wait_frames(NES_FRAMES);
        end_test();

        begin_test("snes");
        write_type(GC_SNES);
        arm_check(GC_SNES);
        wait_frames(SNES_FRAMES);
        end_test();

        // switch rate in the middle of an SNES frame
        begin_test("type change");
        while (!busy) @(negedge clk);
        repeat (40) @(negedge clk);
        check_bit("busy before change", 1'b1, busy);
        write_type(GC_DB15_FAST);
        repeat (2) @(negedge clk);
        check_bit("busy after change", 1'b0, busy);
        arm_check(GC_DB15_FAST);
        wait_frames(FAST_FRAMES);
        end_test();

        // words must stay at the last completed frame
        begin_test("disable");
        write_type(GC_DISABLED);
        repeat (2) @(negedge clk);
        watch_latch_idle(400);
        check_btn("p1 word held", last_exp1, p1_btn);
        check_btn("p2 word held", last_exp2, p2_btn);
        end_test();

        $display("tests passed %0d failed %0d, assertion failures %0d",
                 pass_tests, fail_tests, i_snac_top.u_assert.hits);
        if (fail_tests == 0 && i_snac_top.u_assert.hits == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/snac_pkg.sv
hdl/snac_cfg_if.sv
hdl/snac_cfg_apb.sv
hdl/snac_strobe_gen.sv
hdl/serlatch_reader.sv
hdl/snac_top.sv
tb/tb_clk_gen.sv
tb/snac_assert.sv
tb/snac_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= snac_tb
FILELIST  ?= build.f
# keep running past assertion errors so the testbench can report them
SIM_ARGS  ?= +verilator+error+limit+1000

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
